//--- Bender.yml
package:
  name: t08_io

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/t08_io_pkg.sv
      - hdl/t08_mmio.sv
      - hdl/t08_wb_master.sv
      - hdl/t08_touch_latch.sv
      - hdl/t08_spi_issuer.sv
      - hdl/t08_io_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/t08_io_tb.sv

//--- hdl/t08_io_consts.svh
`ifndef T08_IO_CONSTS_SVH
`define T08_IO_CONSTS_SVH

// io window in the upper half of the address space
`define T08_MMIO_BASE      32'hFFFF_0000
`define T08_MMIO_MASK      32'hFFFF_0000

// register offsets inside the io window
`define T08_TOUCH_OFS      16'h0000
`define T08_SPI_PARAM_OFS  16'h0004
`define T08_SPI_CMD_OFS    16'h0008
`define T08_STATUS_OFS     16'h000C

// system clocks per sck half period
`define T08_SPI_CLK_DIV    2

// parameter bytes after the command on a write job
`define T08_SPI_PARAM_BYTES 4

`endif

//--- hdl/t08_io_pkg.sv
package t08_io_pkg;

    // request from the memory handler
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    // wishbone classic master outputs
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // also the read value of the touch register
    typedef struct packed {
        logic [7:0] xh;
        logic [7:0] xl;
        logic [7:0] yh;
        logic [7:0] yl;
    } touch_t;

    typedef struct packed {
        logic [31:0] params;
        logic [7:0]  cmd;
        logic        readwrite;  // params follow the command
    } spi_job_t;

    typedef enum logic [2:0] {
        region_mem,
        region_touch,
        region_spi_param,
        region_spi_cmd,
        region_status
    } region_t;

endpackage

//--- hdl/t08_io_top.sv
module t08_io_top (
    input  logic                 clk,
    input  logic                 reset,
    input  t08_io_pkg::mem_req_t req,
    input  logic [7:0]           xh,
    input  logic [7:0]           xl,
    input  logic [7:0]           yh,
    input  logic [7:0]           yl,
    input  logic                 done,
    input  t08_io_pkg::wb_rsp_t  wb_rsp,
    output logic [31:0]          mh_data_o,
    output logic                 busy,
    output t08_io_pkg::wb_req_t  wb_req,
    output logic                 sck,
    output logic                 mosi,
    output logic                 cs_n
);
    import t08_io_pkg::*;

    logic        mem_start;
    logic        mem_done;
    logic [31:0] mem_data;
    touch_t      touch;
    logic        touch_valid;
    logic        touch_clear;
    logic        spi_launch;
    logic        spi_busy;
    spi_job_t    spi_job;

    t08_mmio u_mmio (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .mem_done    (mem_done),
        .mem_data    (mem_data),
        .touch       (touch),
        .touch_valid (touch_valid),
        .spi_busy    (spi_busy),
        .mh_data_o   (mh_data_o),
        .busy        (busy),
        .mem_start   (mem_start),
        .touch_clear (touch_clear),
        .spi_launch  (spi_launch),
        .spi_job     (spi_job)
    );

    // memory side takes the request straight from the handler port
    t08_wb_master u_wb_master (
        .clk    (clk),
        .reset  (reset),
        .start  (mem_start),
        .req    (req),
        .wb_rsp (wb_rsp),
        .wb_req (wb_req),
        .done   (mem_done),
        .rdata  (mem_data)
    );

    t08_touch_latch u_touch_latch (
        .clk   (clk),
        .reset (reset),
        .done  (done),
        .xh    (xh),
        .xl    (xl),
        .yh    (yh),
        .yl    (yl),
        .clear (touch_clear),
        .touch (touch),
        .valid (touch_valid)
    );

    t08_spi_issuer u_spi_issuer (
        .clk    (clk),
        .reset  (reset),
        .launch (spi_launch),
        .job    (spi_job),
        .busy   (spi_busy),
        .sck    (sck),
        .mosi   (mosi),
        .cs_n   (cs_n)
    );

endmodule

//--- hdl/t08_mmio.sv
`include "t08_io_consts.svh"

module t08_mmio (
    input  logic                 clk,
    input  logic                 reset,
    input  t08_io_pkg::mem_req_t req,
    input  logic                 mem_done,
    input  logic [31:0]          mem_data,
    input  t08_io_pkg::touch_t   touch,
    input  logic                 touch_valid,
    input  logic                 spi_busy,
    output logic [31:0]          mh_data_o,
    output logic                 busy,
    output logic                 mem_start,
    output logic                 touch_clear,
    output logic                 spi_launch,
    output t08_io_pkg::spi_job_t spi_job
);
    import t08_io_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_wait_mem,
        st_wait_spi
    } state_t;

    state_t      state, next_state;
    region_t     region_dec, region_q;
    logic        unmapped_dec, unmapped_q;
    logic        req_valid;
    logic        write_q;
    logic [31:0] wdata_q;
    logic [31:0] params_q;
    logic [31:0] rdata_q;
    logic [31:0] read_sel;
    logic        cmd_write;

    assign req_valid = req.read ^ req.write;  // both or neither is ignored

    // address decode, only sampled at the request
    always_comb begin
        region_dec   = region_mem;
        unmapped_dec = 1'b0;
        if ((req.addr & `T08_MMIO_MASK) == `T08_MMIO_BASE) begin
            case (req.addr[15:0])
                `T08_TOUCH_OFS:     region_dec = region_touch;
                `T08_SPI_PARAM_OFS: region_dec = region_spi_param;
                `T08_SPI_CMD_OFS:   region_dec = region_spi_cmd;
                `T08_STATUS_OFS:    region_dec = region_status;
                default: begin
                    region_dec   = region_status;
                    unmapped_dec = 1'b1;  // reads zero, writes dropped
                end
            endcase
        end
    end

    assign cmd_write = !unmapped_q && write_q && (region_q == region_spi_cmd);

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (req_valid) begin
                    next_state = (region_dec == region_mem) ? st_wait_mem : st_access;
                end
            end
            st_access: begin
                if (cmd_write && spi_busy) begin
                    next_state = st_wait_spi;
                end else begin
                    next_state = st_idle;
                end
            end
            st_wait_mem: if (mem_done) next_state = st_idle;
            st_wait_spi: if (!spi_busy) next_state = st_idle;
            default:     next_state = st_idle;
        endcase
    end

    // register read mux
    always_comb begin
        read_sel = '0;
        if (!unmapped_q) begin
            case (region_q)
                region_touch:     read_sel = touch;
                region_spi_param: read_sel = params_q;
                region_status:    read_sel = {30'd0, touch_valid, spi_busy};
                default:          read_sel = '0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= st_idle;
            region_q   <= region_mem;
            unmapped_q <= 1'b0;
            write_q    <= 1'b0;
            params_q   <= '0;
            rdata_q    <= '0;
        end else begin
            state <= next_state;
            if (state == st_idle && req_valid) begin
                region_q   <= region_dec;
                unmapped_q <= unmapped_dec;
                write_q    <= req.write;
            end
            if (state == st_access && write_q && !unmapped_q
                && region_q == region_spi_param) begin
                params_q <= wdata_q;
            end
            if (state == st_access && !write_q) begin
                rdata_q <= read_sel;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req_valid) wdata_q <= req.wdata;
    end

    assign busy        = (state != st_idle);
    assign mem_start   = (state == st_idle) && req_valid && (region_dec == region_mem);
    assign touch_clear = (state == st_access) && !write_q && !unmapped_q
                         && (region_q == region_touch);
    // launch once the issuer is free
    assign spi_launch  = cmd_write && !spi_busy
                         && (state == st_access || state == st_wait_spi);
    assign spi_job     = '{params: params_q, cmd: wdata_q[7:0], readwrite: wdata_q[8]};

    assign mh_data_o = (region_q == region_mem) ? mem_data : rdata_q;

endmodule

//--- hdl/t08_spi_issuer.sv
`include "t08_io_consts.svh"

module t08_spi_issuer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 launch,
    input  t08_io_pkg::spi_job_t job,
    output logic                 busy,
    output logic                 sck,
    output logic                 mosi,
    output logic                 cs_n
);
    import t08_io_pkg::*;

    localparam int DIV      = `T08_SPI_CLK_DIV;
    localparam int DIV_W    = $clog2(DIV) + 1;
    localparam int JOB_BITS = 8 + 8 * `T08_SPI_PARAM_BYTES;
    localparam int CNT_W    = $clog2(JOB_BITS + 1);

    typedef enum logic [1:0] {
        s_idle,
        s_shift,
        s_tail   // one clock with cs_n still low after the last bit
    } state_t;

    state_t               state;
    logic [DIV_W-1:0]     div_cnt;
    logic [CNT_W-1:0]     bit_cnt;
    logic [JOB_BITS-1:0]  shift_q;
    logic                 sck_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= s_idle;
            div_cnt <= '0;
            bit_cnt <= '0;
            shift_q <= '0;
            sck_q   <= 1'b0;
        end else begin
            case (state)
                s_idle: begin
                    if (launch) begin
                        state   <= s_shift;
                        div_cnt <= '0;
                        sck_q   <= 1'b0;
                        // command first, params only on a write job
                        shift_q <= {job.cmd, job.readwrite ? job.params : 32'd0};
                        bit_cnt <= job.readwrite ? CNT_W'(JOB_BITS) : CNT_W'(8);
                    end
                end
                s_shift: begin
                    if (div_cnt == DIV_W'(DIV - 1)) begin
                        div_cnt <= '0;
                        if (!sck_q) begin
                            sck_q <= 1'b1;  // display samples here
                        end else begin
                            sck_q   <= 1'b0;
                            shift_q <= shift_q << 1;  // next bit on the falling edge
                            bit_cnt <= bit_cnt - 1'b1;
                            if (bit_cnt == CNT_W'(1)) state <= s_tail;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                s_tail:  state <= s_idle;
                default: state <= s_idle;
            endcase
        end
    end

    assign sck  = sck_q;
    assign mosi = shift_q[JOB_BITS-1];  // msb first
    assign cs_n = (state == s_idle);
    assign busy = (state != s_idle);

endmodule

//--- hdl/t08_touch_latch.sv
module t08_touch_latch (
    input  logic               clk,
    input  logic               reset,
    input  logic               done,
    input  logic [7:0]         xh,
    input  logic [7:0]         xl,
    input  logic [7:0]         yh,
    input  logic [7:0]         yl,
    input  logic               clear,
    output t08_io_pkg::touch_t touch,
    output logic               valid
);
    import t08_io_pkg::*;

    touch_t sample_q;

    // coordinate bytes from the i2c reader
    always_ff @(posedge clk) begin
        if (done) begin
            sample_q <= '{xh: xh, xl: xl, yh: yh, yl: yl};
        end
    end

    // sticky flag, a new sample beats a clear
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (done) begin
            valid <= 1'b1;
        end else if (clear) begin
            valid <= 1'b0;
        end
    end

    assign touch = sample_q;

endmodule

//--- hdl/t08_wb_master.sv
module t08_wb_master (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  t08_io_pkg::mem_req_t req,
    input  t08_io_pkg::wb_rsp_t  wb_rsp,
    output t08_io_pkg::wb_req_t  wb_req,
    output logic                 done,
    output logic [31:0]          rdata
);
    import t08_io_pkg::*;

    logic        cyc_q;
    logic        we_q;
    logic [31:0] adr_q;
    logic [31:0] dat_q;
    logic [31:0] rdata_q;

    // ack ends the cycle, done in the same clock
    assign done = cyc_q & wb_rsp.ack;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
        end else if (start) begin
            cyc_q <= 1'b1;
            we_q  <= req.write;
        end else if (done) begin
            cyc_q <= 1'b0;  // low in the cycle after ack
            we_q  <= 1'b0;
        end
    end

    // address and write data
    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= req.addr;
            dat_q <= req.wdata;
        end
    end

    // read data held until the next read ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdata_q <= '0;
        end else if (done && !we_q) begin
            rdata_q <= wb_rsp.dat;
        end
    end

    assign rdata = rdata_q;

    // single classic cycle so stb tracks cyc
    assign wb_req = '{
        cyc: cyc_q,
        stb: cyc_q,
        we:  we_q,
        adr: adr_q,
        dat: dat_q
    };

endmodule

//--- t08_io_top.f
+incdir+hdl
hdl/t08_io_pkg.sv
hdl/t08_mmio.sv
hdl/t08_wb_master.sv
hdl/t08_touch_latch.sv
hdl/t08_spi_issuer.sv
hdl/t08_io_top.sv
verification/t08_io_tb.sv

//--- verification/t08_io_tb.sv
`include "t08_io_consts.svh"

module t08_io_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import t08_io_pkg::*;

    localparam int SPI_JOB_CYCLES = 40 * 2 * `T08_SPI_CLK_DIV + 2;
    localparam int SPI_CMD_CYCLES = 8 * 2 * `T08_SPI_CLK_DIV + 2;
    localparam int WATCHDOG_CYCLES = 10 + 16 * 10 + 16 * 6 + 3 * SPI_JOB_CYCLES
                                     + 2 * SPI_CMD_CYCLES + 100;
    localparam logic [31:0] TOUCH_ADDR  = `T08_MMIO_BASE | `T08_TOUCH_OFS;
    localparam logic [31:0] PARAM_ADDR  = `T08_MMIO_BASE | `T08_SPI_PARAM_OFS;
    localparam logic [31:0] CMD_ADDR    = `T08_MMIO_BASE | `T08_SPI_CMD_OFS;
    localparam logic [31:0] STATUS_ADDR = `T08_MMIO_BASE | `T08_STATUS_OFS;
    localparam logic [31:0] BAD_ADDR    = `T08_MMIO_BASE | 32'h0010;

    logic        clk;
    logic        reset;
    mem_req_t    req;
    logic [7:0]  xh;
    logic [7:0]  xl;
    logic [7:0]  yh;
    logic [7:0]  yl;
    logic        done;
    wb_rsp_t     wb_rsp = '0;
    logic [31:0] mh_data_o;
    logic        busy;
    wb_req_t     wb_req;
    logic        sck;
    logic        mosi;
    logic        cs_n;

    logic [31:0] rng_state = 32'h434d6fc8;
    logic [31:0] mem_model [0:255];
    logic        wait_armed = 1'b0;
    int          wait_left = 0;
    logic [63:0] spi_word = '0;
    int          spi_count = 0;
    int          job_bits[$];
    logic [63:0] job_data[$];
    int          mismatch_count = 0;
    int          fault_count = 0;

    t08_io_top DUT (
        .clk(clk), .reset(reset), .req(req), .xh(xh), .xl(xl), .yh(yh), .yl(yl),
        .done(done), .wb_rsp(wb_rsp), .mh_data_o(mh_data_o), .busy(busy),
        .wb_req(wb_req), .sck(sck), .mosi(mosi), .cs_n(cs_n)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            mismatch_count++;
            $display("ERR %s expected %0h actual %0h", name, exp, act);
        end
    endtask

    task automatic fault(input string name, input string what);
        fault_count++;
        $display("%s failed: %s", name, what);
    endtask

    // pattern over the whole word address
    initial begin
        for (int i = 0; i < 256; i++) mem_model[i] = 32'h9e37_79b9 * (i + 1);
    end

    // wishbone slave with 0 to 3 wait cycles
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_rsp <= '0;
            wait_armed = 1'b0;
        end else begin
            wb_rsp.ack <= 1'b0;
            if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
                if (!wait_armed) begin
                    wait_armed = 1'b1;
                    wait_left = next_random() % 4;
                end
                if (wait_left == 0) begin
                    wait_armed = 1'b0;
                    wb_rsp.ack <= 1'b1;
                    if (wb_req.we) begin
                        mem_model[wb_req.adr[9:2]] <= wb_req.dat;
                    end else begin
                        wb_rsp.dat <= mem_model[wb_req.adr[9:2]];
                    end
                end else begin
                    wait_left--;
                end
            end
        end
    end

    // display side, one entry per finished job
    always @(posedge sck) begin
        if (!cs_n) begin
            spi_word = {spi_word[62:0], mosi};
            spi_count++;
        end
    end

    always @(posedge cs_n) begin
        job_bits.push_back(spi_count);
        job_data.push_back(spi_word);
        spi_count = 0;
        spi_word = '0;
    end

    // one request from the memory handler, returns at the negedge busy is low
    task automatic access(input string name, input logic rd, input logic [31:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic bus_used, output int cycles);
        logic acked;
        acked = 1'b0;
        bus_used = 1'b0;
        cycles = 0;
        @(posedge clk);
        req <= '{read: rd, write: !rd, addr: addr, wdata: wdata};
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        while (busy && cycles < 400) begin
            if (wb_req.cyc) bus_used = 1'b1;
            if (addr < `T08_MMIO_BASE) begin
                if (acked) fault(name, "busy still high a cycle after ack");
                if (!wb_req.cyc || !wb_req.stb) fault(name, "cyc or stb low before ack");
                if (cycles == 0 && wb_req.we !== !rd) fault(name, "we does not follow request");
                if (cycles == 0) compare({name, " adr"}, addr, wb_req.adr);
                if (wb_rsp.ack) acked = 1'b1;
            end
            cycles++;
            @(negedge clk);
        end
        if (busy) fault(name, "busy never fell");
        if (addr < `T08_MMIO_BASE && !acked) fault(name, "busy fell without an ack");
        if (addr < `T08_MMIO_BASE && wb_req.cyc) fault(name, "cyc still high after ack");
        rdata = mh_data_o;
    endtask

    // i2c reader delivers one sample
    task automatic pulse_touch(input logic [31:0] sample);
        @(posedge clk);
        {xh, xl, yh, yl} <= sample;
        done <= 1'b1;
        @(posedge clk);
        done <= 1'b0;
    endtask

    task automatic wait_jobs(input string name, input int count, output int low_cycles);
        int n;
        n = 0;
        low_cycles = 0;
        while (job_bits.size() < count && n < 3 * SPI_JOB_CYCLES) begin
            if (!cs_n) low_cycles++;
            n++;
            @(negedge clk);
        end
        if (job_bits.size() < count) fault(name, "spi job never finished");
    endtask

    task automatic test_reset_unmapped();
        logic [31:0] rdata;
        logic        used;
        int          cycles;
        @(negedge clk);
        compare("reset busy", 0, busy);
        compare("reset cyc", 0, wb_req.cyc);
        compare("reset we", 0, wb_req.we);
        compare("reset cs_n", 1, cs_n);
        compare("reset sck", 0, sck);
        // nonzero status and touch so an alias of offset 16 shows up
        pulse_touch(32'ha1b2_c3d4);
        access("unmapped status", 1'b1, STATUS_ADDR, '0, rdata, used, cycles);
        compare("unmapped status", 32'h2, rdata);
        access("unmapped read", 1'b1, BAD_ADDR, '0, rdata, used, cycles);
        compare("unmapped read", 0, rdata);
        compare("unmapped busy cycles", 1, cycles);
        access("unmapped touch", 1'b1, TOUCH_ADDR, '0, rdata, used, cycles);
        compare("unmapped touch", 32'ha1b2_c3d4, rdata);
        access("unmapped write", 1'b0, BAD_ADDR, 32'h5555_aaaa, rdata, used, cycles);
        compare("unmapped write cyc", 0, used);
    endtask

    task automatic test_memory();
        logic [31:0] addrs [8];
        logic [31:0] words [8];
        logic [31:0] rdata;
        logic        used;
        int          cycles;
        for (int i = 0; i < 8; i++) begin
            addrs[i] = (next_random() & 32'h7fff_fc00) | (i << 2);  // distinct words
            words[i] = next_random();
            access("memory write", 1'b0, addrs[i], words[i], rdata, used, cycles);
        end
        for (int i = 0; i < 8; i++) begin
            access("memory read", 1'b1, addrs[i], '0, rdata, used, cycles);
            compare("memory read", words[i], rdata);
        end
    endtask

    task automatic test_touch();
        logic [31:0] rdata;
        logic        used;
        int          cycles;
        pulse_touch({8'h12, 8'h34, 8'h56, 8'h78});
        access("touch status", 1'b1, STATUS_ADDR, '0, rdata, used, cycles);
        compare("touch status before", 32'h2, rdata);
        access("touch read", 1'b1, TOUCH_ADDR, '0, rdata, used, cycles);
        compare("touch read", {8'h12, 8'h34, 8'h56, 8'h78}, rdata);
        access("touch status", 1'b1, STATUS_ADDR, '0, rdata, used, cycles);
        compare("touch status after", 32'h0, rdata);
    endtask

    task automatic test_spi_write();
        logic [31:0] rdata;
        logic        used;
        int          cycles;
        int          low_cycles;
        access("spi write", 1'b0, PARAM_ADDR, 32'hdead_beef, rdata, used, cycles);
        access("spi write", 1'b0, CMD_ADDR, 32'h0000_01a5, rdata, used, cycles);
        wait_jobs("spi write", 1, low_cycles);
        compare("spi write bits", 40, job_bits[0]);
        compare("spi write data", {8'ha5, 32'hdead_beef}, job_data[0]);
        compare("spi write length", SPI_JOB_CYCLES - 1, low_cycles);  // launch cycle not counted
        compare("spi write cs_n", 1, cs_n);
        job_bits.delete();
        job_data.delete();
    endtask

    task automatic test_spi_command();
        logic [31:0] rdata;
        logic        used;
        int          cycles;
        int          low_cycles;
        access("spi command", 1'b0, CMD_ADDR, 32'h0000_003c, rdata, used, cycles);
        access("spi command", 1'b1, STATUS_ADDR, '0, rdata, used, cycles);
        compare("spi command status", 32'h1, rdata);
        wait_jobs("spi command", 1, low_cycles);
        compare("spi command bits", 8, job_bits[0]);
        compare("spi command data", 8'h3c, job_data[0]);
        compare("spi command cs_n", 1, cs_n);
        job_bits.delete();
        job_data.delete();
    endtask

    task automatic test_back_pressure();
        logic [31:0] rdata;
        logic        used;
        int          cycles;
        int          low_cycles;
        access("back pressure", 1'b0, CMD_ADDR, 32'h0000_0011, rdata, used, cycles);
        access("back pressure", 1'b0, CMD_ADDR, 32'h0000_0122, rdata, used, cycles);
        compare("back pressure first job done", 1, job_bits.size());
        compare("back pressure second job running", 0, cs_n);
        wait_jobs("back pressure", 2, low_cycles);
        compare("back pressure first bits", 8, job_bits[0]);
        compare("back pressure first data", 8'h11, job_data[0]);
        compare("back pressure second bits", 40, job_bits[1]);
        compare("back pressure second data", {8'h22, 32'hdead_beef}, job_data[1]);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        reset = 1'b1;
        req = '0;
        xh = '0;
        xl = '0;
        yh = '0;
        yl = '0;
        done = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        job_bits.delete();  // drop the cs_n edge from reset
        job_data.delete();
        test_reset_unmapped();
        test_memory();
        test_touch();
        test_spi_write();
        test_spi_command();
        test_back_pressure();
        $display("mismatches %0d, other failures %0d", mismatch_count, fault_count);
        if (mismatch_count == 0 && fault_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
